// File: axi_periph_consts.svh
`ifndef AXI_PERIPH_CONSTS_SVH
`define AXI_PERIPH_CONSTS_SVH

////////////////////
// Address map
////////////////////

`define AXI_UART_BASE      32'h1000_0000
`define AXI_UART_MASK      32'hFFFF_F000   // 4 KB window.
`define AXI_TIMER_BASE     32'h0200_0000
`define AXI_TIMER_MASK     32'hFFFF_0000   // 64 KB window.

////////////////////
// UART
////////////////////

`define UART_CLKS_PER_BIT  8               // Clocks per serial bit.

////////////////////
// AXI response codes
////////////////////

`define AXI_RESP_OKAY      2'b00
`define AXI_RESP_SLVERR    2'b10
`define AXI_RESP_DECERR    2'b11

`endif

// File: axi_periph_pkg.sv
package axi_periph_pkg;

    ////////////////////
    // AXI4-Lite channels
    ////////////////////

    typedef struct packed {
        logic [31:0] addr;
    } axi_ar_t;

    typedef struct packed {
        logic [31:0] addr;
    } axi_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } axi_w_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
    } axi_r_t;

    typedef struct packed {
        logic [1:0] resp;
    } axi_b_t;

    ////////////////////
    // Internal device bus
    ////////////////////

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } periph_op_e;

    typedef struct packed {
        periph_op_e  op;
        logic [11:0] offset;    // Byte offset inside the device window.
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } periph_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;       // Mapped to SLVERR by the xbar.
    } periph_rsp_t;

    typedef enum logic [1:0] {
        TGT_UART,
        TGT_TIMER,
        TGT_NONE
    } periph_tgt_e;

endpackage

// File: axi_periph_xbar.sv
`timescale 1ns/1ps
`include "axi_periph_consts.svh"

module axi_periph_xbar (
    input  logic                         clk,
    input  logic                         rst,

    input  axi_periph_pkg::axi_ar_t      ar,
    input  logic                         arvalid,
    output logic                         arready,

    input  axi_periph_pkg::axi_aw_t      aw,
    input  logic                         awvalid,
    output logic                         awready,

    input  axi_periph_pkg::axi_w_t       w,
    input  logic                         wvalid,
    output logic                         wready,

    output axi_periph_pkg::axi_r_t       r,
    output logic                         rvalid,
    input  logic                         rready,

    output axi_periph_pkg::axi_b_t       b,
    output logic                         bvalid,
    input  logic                         bready,

    output axi_periph_pkg::periph_req_t  uart_req,
    output logic                         uart_req_valid,
    input  axi_periph_pkg::periph_rsp_t  uart_rsp,
    input  logic                         uart_rsp_valid,

    output axi_periph_pkg::periph_req_t  timer_req,
    output logic                         timer_req_valid,
    input  axi_periph_pkg::periph_rsp_t  timer_rsp,
    input  logic                         timer_rsp_valid
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WAIT_W,
        ST_ISSUE,
        ST_WAIT_RSP,
        ST_RESP
    } xbar_state_e;

    xbar_state_e                  state_q;
    axi_periph_pkg::periph_op_e   op_q;
    axi_periph_pkg::periph_tgt_e  tgt_q;
    logic [11:0]                  offset_q;
    logic [31:0]                  wdata_q;
    logic [3:0]                   wstrb_q;
    axi_periph_pkg::axi_r_t       r_q;
    axi_periph_pkg::periph_req_t  req;
    axi_periph_pkg::periph_rsp_t  dev_rsp;
    logic                         dev_rsp_valid;

    function automatic axi_periph_pkg::periph_tgt_e decode(input logic [31:0] addr);
        if ((addr & `AXI_UART_MASK) == `AXI_UART_BASE)
            return axi_periph_pkg::TGT_UART;
        if ((addr & `AXI_TIMER_MASK) == `AXI_TIMER_BASE)
            return axi_periph_pkg::TGT_TIMER;
        return axi_periph_pkg::TGT_NONE;
    endfunction

    assign arready = (state_q == ST_IDLE);
    assign awready = (state_q == ST_IDLE) && !arvalid;   // Reads win a tie.
    assign wready  = (state_q == ST_WAIT_W);
    assign rvalid  = (state_q == ST_RESP) && (op_q == axi_periph_pkg::OP_READ);
    assign bvalid  = (state_q == ST_RESP) && (op_q == axi_periph_pkg::OP_WRITE);
    assign r       = r_q;
    assign b       = '{resp: r_q.resp};

    ////////////////////
    // Device side
    ////////////////////

    assign req = '{op: op_q, offset: offset_q, wdata: wdata_q, wstrb: wstrb_q};

    assign uart_req        = req;
    assign timer_req       = req;
    assign uart_req_valid  = (state_q == ST_ISSUE) && (tgt_q == axi_periph_pkg::TGT_UART);
    assign timer_req_valid = (state_q == ST_ISSUE) && (tgt_q == axi_periph_pkg::TGT_TIMER);

    assign dev_rsp       = (tgt_q == axi_periph_pkg::TGT_TIMER) ? timer_rsp : uart_rsp;
    assign dev_rsp_valid = (tgt_q == axi_periph_pkg::TGT_TIMER) ? timer_rsp_valid :
                           (tgt_q == axi_periph_pkg::TGT_UART)  ? uart_rsp_valid  : 1'b0;

    ////////////////////
    // Control FSM
    ////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q  <= ST_IDLE;
            op_q     <= axi_periph_pkg::OP_READ;
            tgt_q    <= axi_periph_pkg::TGT_NONE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (arvalid) begin
                        op_q    <= axi_periph_pkg::OP_READ;
                        tgt_q   <= decode(ar.addr);
                        state_q <= ST_ISSUE;
                    end else if (awvalid) begin
                        op_q    <= axi_periph_pkg::OP_WRITE;
                        tgt_q   <= decode(aw.addr);
                        state_q <= ST_WAIT_W;
                    end
                end
                ST_WAIT_W: begin
                    if (wvalid)
                        state_q <= ST_ISSUE;
                end
                ST_ISSUE: begin
                    if (tgt_q == axi_periph_pkg::TGT_NONE)
                        state_q <= ST_RESP;
                    else
                        state_q <= ST_WAIT_RSP;
                end
                ST_WAIT_RSP: begin
                    if (dev_rsp_valid)
                        state_q <= ST_RESP;
                end
                ST_RESP: begin
                    if ((rvalid && rready) || (bvalid && bready))
                        state_q <= ST_IDLE;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Request and response payload.
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && arvalid)
            offset_q <= ar.addr[11:0];
        else if (state_q == ST_IDLE && awvalid)
            offset_q <= aw.addr[11:0];
        if (state_q == ST_WAIT_W && wvalid) begin
            wdata_q <= w.data;
            wstrb_q <= w.strb;
        end
        if (state_q == ST_ISSUE && tgt_q == axi_periph_pkg::TGT_NONE) begin
            r_q.data <= 32'h0;
            r_q.resp <= `AXI_RESP_DECERR;
        end
        if (state_q == ST_WAIT_RSP && dev_rsp_valid) begin
            r_q.data <= dev_rsp.rdata;
            r_q.resp <= dev_rsp.err ? `AXI_RESP_SLVERR : `AXI_RESP_OKAY;
        end
    end

    a_one_response: assert property (@(posedge clk) disable iff (rst) !(rvalid && bvalid));

    a_uart_strobe: assert property (@(posedge clk) disable iff (rst)
        uart_req_valid |=> !uart_req_valid);

    a_timer_strobe: assert property (@(posedge clk) disable iff (rst)
        timer_req_valid |=> !timer_req_valid);

endmodule

// File: axi_uart.sv
`timescale 1ns/1ps
`include "axi_periph_consts.svh"

module axi_uart #(
    parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
    input  logic                         clk,
    input  logic                         rst,
    input  axi_periph_pkg::periph_req_t  req,
    input  logic                         req_valid,
    output axi_periph_pkg::periph_rsp_t  rsp,
    output logic                         rsp_valid,
    output logic                         tx
);

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    tx_state_e                    state_q;
    logic [CNT_W-1:0]             clk_cnt_q;
    logic [2:0]                   bit_cnt_q;
    logic [7:0]                   hold_q;
    logic                         hold_full_q;
    logic [7:0]                   shift_q;
    logic                         tx_q;
    logic                         bit_done;
    logic                         busy;
    logic                         load_hold;
    logic                         take_hold;
    axi_periph_pkg::periph_rsp_t  rsp_d;
    axi_periph_pkg::periph_rsp_t  rsp_q;
    logic                         rsp_valid_q;

    assign busy      = (state_q != TX_IDLE);
    assign bit_done  = (clk_cnt_q == CNT_W'(CLKS_PER_BIT - 1));
    assign take_hold = (state_q == TX_IDLE) && hold_full_q;
    assign tx        = tx_q;
    assign rsp       = rsp_q;
    assign rsp_valid = rsp_valid_q;

    ////////////////////
    // Register access
    ////////////////////

    always_comb begin
        load_hold   = 1'b0;
        rsp_d.rdata = 32'h0;
        rsp_d.err   = 1'b0;
        case (req.offset)
            12'h000: begin   // TXDATA, reads as zero.
                if (req.op == axi_periph_pkg::OP_WRITE && req.wstrb[0]) begin
                    if (hold_full_q)
                        rsp_d.err = 1'b1;
                    else
                        load_hold = req_valid;
                end
            end
            12'h004: rsp_d.rdata = {30'h0, busy, hold_full_q};   // STATUS.
            default: rsp_d.err = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (req_valid)
            rsp_q <= rsp_d;
        if (load_hold)
            hold_q <= req.wdata[7:0];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp_valid_q <= 1'b0;
            hold_full_q <= 1'b0;
        end else begin
            rsp_valid_q <= req_valid;
            if (take_hold)
                hold_full_q <= 1'b0;
            else if (load_hold)
                hold_full_q <= 1'b1;
        end
    end

    ////////////////////
    // Serializer
    ////////////////////

    always_ff @(posedge clk) begin
        if (take_hold)
            shift_q <= hold_q;
        else if (state_q == TX_DATA && bit_done)
            shift_q <= shift_q >> 1;   // LSB first.
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q   <= TX_IDLE;
            clk_cnt_q <= '0;
            bit_cnt_q <= 3'd0;
            tx_q      <= 1'b1;
        end else begin
            if (state_q == TX_IDLE || bit_done)
                clk_cnt_q <= '0;
            else
                clk_cnt_q <= clk_cnt_q + 1'b1;
            case (state_q)
                TX_IDLE: begin
                    if (hold_full_q) begin
                        state_q <= TX_START;
                        tx_q    <= 1'b0;   // Start bit.
                    end
                end
                TX_START: begin
                    if (bit_done) begin
                        state_q   <= TX_DATA;
                        bit_cnt_q <= 3'd0;
                        tx_q      <= shift_q[0];
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        if (bit_cnt_q == 3'd7) begin
                            state_q <= TX_STOP;
                            tx_q    <= 1'b1;
                        end else begin
                            bit_cnt_q <= bit_cnt_q + 3'd1;
                            tx_q      <= shift_q[1];
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_done)
                        state_q <= TX_IDLE;
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    a_idle_line: assert property (@(posedge clk) disable iff (rst) (state_q == TX_IDLE) |-> tx);

endmodule

// File: axi_timer.sv
`timescale 1ns/1ps

module axi_timer (
    input  logic                         clk,
    input  logic                         rst,
    input  axi_periph_pkg::periph_req_t  req,
    input  logic                         req_valid,
    output axi_periph_pkg::periph_rsp_t  rsp,
    output logic                         rsp_valid,
    output logic                         timer_irq
);

    logic [63:0]                  mtime_q;
    logic [63:0]                  mtimecmp_q;
    logic                         irq_q;
    logic                         wr;
    axi_periph_pkg::periph_rsp_t  rsp_d;
    axi_periph_pkg::periph_rsp_t  rsp_q;
    logic                         rsp_valid_q;

    function automatic logic [31:0] merge(input logic [31:0] old,
                                          input logic [31:0] wdata,
                                          input logic [3:0]  strb);
        logic [31:0] res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i])
                res[8*i +: 8] = wdata[8*i +: 8];
        end
        return res;
    endfunction

    assign wr        = req_valid && (req.op == axi_periph_pkg::OP_WRITE);
    assign rsp       = rsp_q;
    assign rsp_valid = rsp_valid_q;
    assign timer_irq = irq_q;

    always_comb begin
        rsp_d.err = 1'b0;
        case (req.offset)
            12'h000: rsp_d.rdata = mtime_q[31:0];
            12'h004: rsp_d.rdata = mtime_q[63:32];
            12'h008: rsp_d.rdata = mtimecmp_q[31:0];
            12'h00C: rsp_d.rdata = mtimecmp_q[63:32];
            default: begin
                rsp_d.rdata = 32'h0;
                rsp_d.err   = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (req_valid)
            rsp_q <= rsp_d;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mtime_q     <= 64'h0;
            mtimecmp_q  <= '1;   // Keeps the interrupt low until programmed.
            irq_q       <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= req_valid;
            if (wr && req.offset == 12'h000)
                mtime_q <= {mtime_q[63:32], merge(mtime_q[31:0], req.wdata, req.wstrb)};
            else if (wr && req.offset == 12'h004)
                mtime_q <= {merge(mtime_q[63:32], req.wdata, req.wstrb), mtime_q[31:0]};
            else
                mtime_q <= mtime_q + 64'd1;
            if (wr && req.offset == 12'h008)
                mtimecmp_q[31:0] <= merge(mtimecmp_q[31:0], req.wdata, req.wstrb);
            if (wr && req.offset == 12'h00C)
                mtimecmp_q[63:32] <= merge(mtimecmp_q[63:32], req.wdata, req.wstrb);
            irq_q <= (mtime_q >= mtimecmp_q);
        end
    end

endmodule

// File: axi_periph_top.sv
`timescale 1ns/1ps

module axi_periph_top (
    input  logic                     clk,
    input  logic                     rst,

    input  axi_periph_pkg::axi_ar_t  ar,
    input  logic                     arvalid,
    output logic                     arready,

    input  axi_periph_pkg::axi_aw_t  aw,
    input  logic                     awvalid,
    output logic                     awready,

    input  axi_periph_pkg::axi_w_t   w,
    input  logic                     wvalid,
    output logic                     wready,

    output axi_periph_pkg::axi_r_t   r,
    output logic                     rvalid,
    input  logic                     rready,

    output axi_periph_pkg::axi_b_t   b,
    output logic                     bvalid,
    input  logic                     bready,

    output logic                     tx,
    output logic                     timer_irq
);

    axi_periph_pkg::periph_req_t  uart_req;
    logic                         uart_req_valid;
    axi_periph_pkg::periph_rsp_t  uart_rsp;
    logic                         uart_rsp_valid;
    axi_periph_pkg::periph_req_t  timer_req;
    logic                         timer_req_valid;
    axi_periph_pkg::periph_rsp_t  timer_rsp;
    logic                         timer_rsp_valid;

    axi_periph_xbar u_xbar (
        .clk             (clk),
        .rst             (rst),
        .ar              (ar),
        .arvalid         (arvalid),
        .arready         (arready),
        .aw              (aw),
        .awvalid         (awvalid),
        .awready         (awready),
        .w               (w),
        .wvalid          (wvalid),
        .wready          (wready),
        .r               (r),
        .rvalid          (rvalid),
        .rready          (rready),
        .b               (b),
        .bvalid          (bvalid),
        .bready          (bready),
        .uart_req        (uart_req),
        .uart_req_valid  (uart_req_valid),
        .uart_rsp        (uart_rsp),
        .uart_rsp_valid  (uart_rsp_valid),
        .timer_req       (timer_req),
        .timer_req_valid (timer_req_valid),
        .timer_rsp       (timer_rsp),
        .timer_rsp_valid (timer_rsp_valid)
    );

    axi_uart u_uart (
        .clk       (clk),
        .rst       (rst),
        .req       (uart_req),
        .req_valid (uart_req_valid),
        .rsp       (uart_rsp),
        .rsp_valid (uart_rsp_valid),
        .tx        (tx)
    );

    axi_timer u_timer (
        .clk       (clk),
        .rst       (rst),
        .req       (timer_req),
        .req_valid (timer_req_valid),
        .rsp       (timer_rsp),
        .rsp_valid (timer_rsp_valid),
        .timer_irq (timer_irq)
    );

endmodule

// File: tb_axi_periph.sv
`timescale 1ns/1ps
`include "axi_periph_consts.svh"

module tb_axi_periph;

    localparam int BIT_CLKS        = `UART_CLKS_PER_BIT;
    localparam int NUM_FRAMES      = 4;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * 10 * BIT_CLKS + 2000;
    localparam logic [31:0] UART   = `AXI_UART_BASE;
    localparam logic [31:0] TIMER  = `AXI_TIMER_BASE;

    logic                     clk;
    logic                     rst;
    axi_periph_pkg::axi_ar_t  ar;
    logic                     arvalid;
    logic                     arready;
    axi_periph_pkg::axi_aw_t  aw;
    logic                     awvalid;
    logic                     awready;
    axi_periph_pkg::axi_w_t   w;
    logic                     wvalid;
    logic                     wready;
    axi_periph_pkg::axi_r_t   r;
    logic                     rvalid;
    logic                     rready;
    axi_periph_pkg::axi_b_t   b;
    logic                     bvalid;
    logic                     bready;
    logic                     tx;
    logic                     timer_irq;
    int                       errors = 0;
    int                       checks = 0;
    logic [31:0]              rng_state = 32'd96;
    logic [7:0]               rx_bytes[$];

    axi_periph_top u_axi_periph_top (
        .clk(clk), .rst(rst),
        .ar(ar), .arvalid(arvalid), .arready(arready),
        .aw(aw), .awvalid(awvalid), .awready(awready),
        .w(w), .wvalid(wvalid), .wready(wready),
        .r(r), .rvalid(rvalid), .rready(rready),
        .b(b), .bvalid(bvalid), .bready(bready),
        .tx(tx), .timer_irq(timer_irq)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic wait_drive_slot();
        @(posedge clk);
        #2;
    endtask

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic check_r(input string name, input axi_periph_pkg::axi_r_t got,
                           input axi_periph_pkg::axi_r_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s expected data=%h resp=%0d, got data=%h resp=%0d",
                     $time, name, exp.data, exp.resp, got.data, got.resp);
        end
    endtask

    task automatic check_b(input string name, input axi_periph_pkg::axi_b_t got,
                           input axi_periph_pkg::axi_b_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s expected resp=%0d, got resp=%0d",
                     $time, name, exp.resp, got.resp);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s expected %b, got %b", $time, name, exp, got);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("Test %-14s %s", name, (errors == errors_before) ? "passed" : "had errors");
    endtask

    ////////////////////
    // AXI driver
    ////////////////////

    task automatic axi_read(input logic [31:0] addr, input int hold,
                            output axi_periph_pkg::axi_r_t rd);
        axi_periph_pkg::axi_r_t first;
        wait_drive_slot();
        ar.addr = addr;
        arvalid = 1'b1;
        do @(negedge clk); while (!arready);
        wait_drive_slot();
        arvalid = 1'b0;
        do @(negedge clk); while (!rvalid);
        first = r;
        repeat (hold) begin
            @(negedge clk);
            checks++;
            if (rvalid !== 1'b1 || r !== first) begin
                errors++;
                $display("Read response changed at %0t ns while rready was held low", $time);
            end
        end
        wait_drive_slot();
        rready = 1'b1;
        wait_drive_slot();
        rready = 1'b0;
        rd = first;
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output axi_periph_pkg::axi_b_t wr);
        wait_drive_slot();
        aw.addr = addr;
        awvalid = 1'b1;
        w.data  = data;
        w.strb  = strb;
        wvalid  = 1'b1;
        do @(negedge clk); while (!awready);
        wait_drive_slot();
        awvalid = 1'b0;
        do @(negedge clk); while (!wready);
        wait_drive_slot();
        wvalid = 1'b0;
        do @(negedge clk); while (!bvalid);
        wr = b;
        wait_drive_slot();
        bready = 1'b1;
        wait_drive_slot();
        bready = 1'b0;
    endtask

    // 8N1 receiver that samples at mid-bit on the falling clock.
    initial begin : uart_monitor
        logic [7:0] data;
        @(negedge rst);
        forever begin
            @(negedge tx);
            repeat (BIT_CLKS / 2) @(negedge clk);
            if (tx !== 1'b0) begin
                errors++;
                $display("UART start bit at %0t ns was shorter than half a bit", $time);
            end else begin
                for (int i = 0; i < 8; i++) begin
                    repeat (BIT_CLKS) @(negedge clk);
                    data[i] = tx;   // LSB first.
                end
                repeat (BIT_CLKS) @(negedge clk);
                if (tx !== 1'b1) begin
                    errors++;
                    $display("UART frame ending at %0t ns has no stop bit", $time);
                end
                rx_bytes.push_back(data);
            end
        end
    end

    ////////////////////
    // Tests
    ////////////////////

    task automatic test_reset();
        int e0;
        axi_periph_pkg::axi_r_t rd;
        e0 = errors;
        @(negedge clk);
        check_bit("arready", arready, 1'b1);
        check_bit("awready", awready, 1'b1);
        check_bit("wready", wready, 1'b0);
        check_bit("rvalid", rvalid, 1'b0);
        check_bit("bvalid", bvalid, 1'b0);
        check_bit("tx", tx, 1'b1);
        check_bit("timer_irq", timer_irq, 1'b0);
        axi_read(UART + 32'h4, 0, rd);
        check_r("r uart status", rd, '{data: 32'h0, resp: `AXI_RESP_OKAY});
        report_test("reset", e0);
    endtask

    task automatic test_uart_tx();
        int e0;
        logic [31:0] rnd;
        logic [7:0] sent[$];
        axi_periph_pkg::axi_r_t rd;
        axi_periph_pkg::axi_b_t wr;
        e0 = errors;
        for (int i = 0; i < NUM_FRAMES; i++) begin
            do axi_read(UART + 32'h4, 0, rd); while (rd.data[0]);
            rnd = next_random();
            axi_write(UART, rnd, 4'b0001, wr);
            check_b("b uart txdata", wr, '{resp: `AXI_RESP_OKAY});
            sent.push_back(rnd[7:0]);
        end
        rnd = next_random();   // Holding register still has the last byte.
        axi_write(UART, rnd, 4'b0001, wr);
        check_b("b uart txdata full", wr, '{resp: `AXI_RESP_SLVERR});
        do axi_read(UART + 32'h4, 0, rd); while (rd.data[1:0] != 2'b00);
        repeat (2 * BIT_CLKS) @(posedge clk);
        checks++;
        if (rx_bytes.size() != sent.size()) begin
            errors++;
            $display("UART monitor saw %0d bytes but %0d were accepted",
                     rx_bytes.size(), sent.size());
        end
        for (int i = 0; i < sent.size() && i < rx_bytes.size(); i++)
            check_byte("tx byte", rx_bytes[i], sent[i]);
        report_test("uart_tx", e0);
    endtask

    task automatic test_decode();
        int e0;
        axi_periph_pkg::axi_r_t rd;
        axi_periph_pkg::axi_b_t wr;
        e0 = errors;
        axi_read(32'h3000_0000, 0, rd);
        check_r("r unmapped", rd, '{data: 32'h0, resp: `AXI_RESP_DECERR});
        axi_write(32'h3000_0000, next_random(), 4'hF, wr);
        check_b("b unmapped", wr, '{resp: `AXI_RESP_DECERR});
        axi_read(UART, 0, rd);
        check_r("r uart txdata", rd, '{data: 32'h0, resp: `AXI_RESP_OKAY});
        axi_read(UART + 32'h8, 0, rd);
        check_r("r uart bad offset", rd, '{data: 32'h0, resp: `AXI_RESP_SLVERR});
        axi_write(UART + 32'h8, next_random(), 4'hF, wr);
        check_b("b uart bad offset", wr, '{resp: `AXI_RESP_SLVERR});
        axi_read(TIMER + 32'h10, 0, rd);
        check_r("r timer bad offset", rd, '{data: 32'h0, resp: `AXI_RESP_SLVERR});
        axi_write(TIMER + 32'h10, next_random(), 4'hF, wr);
        check_b("b timer bad offset", wr, '{resp: `AXI_RESP_SLVERR});
        report_test("decode", e0);
    endtask

    task automatic wait_irq(input logic level);
        int n;
        n = 0;
        while (timer_irq !== level && n < 4) begin
            @(negedge clk);
            n++;
        end
        check_bit("timer_irq", timer_irq, level);
    endtask

    task automatic test_timer();
        int e0;
        logic [63:0] set_val;
        logic [63:0] now;
        logic [31:0] lo;
        logic [31:0] cmp_full;
        logic [31:0] rnd;
        axi_periph_pkg::axi_r_t rd;
        axi_periph_pkg::axi_b_t wr;
        e0 = errors;
        set_val = 64'h0000_0012_4000_0000;
        axi_write(TIMER, set_val[31:0], 4'hF, wr);
        check_b("b mtime_lo", wr, '{resp: `AXI_RESP_OKAY});
        axi_write(TIMER + 32'h4, set_val[63:32], 4'hF, wr);
        check_b("b mtime_hi", wr, '{resp: `AXI_RESP_OKAY});
        axi_read(TIMER, 0, rd);
        lo = rd.data;
        axi_read(TIMER + 32'h4, 0, rd);
        now = {rd.data, lo};
        checks++;
        if (now < set_val || now >= set_val + 64'd16) begin
            errors++;
            $display("Error at %0t ns: mtime expected %h to %h, got %h",
                     $time, set_val, set_val + 64'd15, now);
        end
        axi_write(TIMER + 32'h8, 32'h0, 4'hF, wr);
        axi_write(TIMER + 32'hC, 32'h0, 4'hF, wr);
        wait_irq(1'b1);
        axi_write(TIMER + 32'hC, 32'hFFFF_FFFF, 4'hF, wr);
        wait_irq(1'b0);
        cmp_full = 32'h1122_3344;
        rnd      = next_random();
        axi_write(TIMER + 32'h8, cmp_full, 4'hF, wr);
        axi_write(TIMER + 32'h8, rnd, 4'b0101, wr);
        check_b("b mtimecmp_lo strobed", wr, '{resp: `AXI_RESP_OKAY});
        axi_read(TIMER + 32'h8, 0, rd);
        check_r("r mtimecmp_lo", rd,
                '{data: (cmp_full & 32'hFF00_FF00) | (rnd & 32'h00FF_00FF),
                  resp: `AXI_RESP_OKAY});
        report_test("timer", e0);
    endtask

    task automatic test_ordering();
        int e0;
        time t_read;
        time t_write;
        logic [31:0] v1;
        logic [31:0] v2;
        axi_periph_pkg::axi_r_t rd;
        axi_periph_pkg::axi_b_t wr;
        e0 = errors;
        v1 = next_random();
        v2 = next_random();
        axi_write(TIMER + 32'h8, v1, 4'hF, wr);
        axi_read(TIMER + 32'h8, 10, rd);
        check_r("r held", rd, '{data: v1, resp: `AXI_RESP_OKAY});
        fork
            begin
                axi_read(TIMER + 32'h8, 0, rd);
                t_read = $time;
            end
            begin
                axi_write(TIMER + 32'h8, v2, 4'hF, wr);
                t_write = $time;
            end
        join
        check_r("r before write", rd, '{data: v1, resp: `AXI_RESP_OKAY});
        check_b("b after read", wr, '{resp: `AXI_RESP_OKAY});
        checks++;
        if (t_read >= t_write) begin
            errors++;
            $display("The write finished before the read it arrived with");
        end
        axi_read(TIMER + 32'h8, 0, rd);
        check_r("r after write", rd, '{data: v2, resp: `AXI_RESP_OKAY});
        report_test("ordering", e0);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        rst     = 1'b1;
        ar      = '0;
        arvalid = 1'b0;
        aw      = '0;
        awvalid = 1'b0;
        w       = '0;
        wvalid  = 1'b0;
        rready  = 1'b0;
        bready  = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        test_reset();
        test_uart_tx();
        test_decode();
        test_timer();
        test_ordering();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: axi_periph.f
+incdir+.
axi_periph_pkg.sv
axi_periph_xbar.sv
axi_uart.sv
axi_timer.sv
axi_periph_top.sv
tb_axi_periph.sv

// File: Makefile
# Verilator flow for the AXI4-Lite peripheral subsystem.

VERILATOR ?= verilator
TB_TOP    ?= tb_axi_periph
RTL_TOP   ?= axi_periph_top
FILELIST  ?= axi_periph.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

SOURCES := $(shell grep -v '^+' $(FILELIST)) axi_periph_consts.svh

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(OBJ_DIR)/V$(TB_TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TB_TOP)
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '^ALL CHECKS PASSED$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
